//--- vlog.f
design/tcdm_pkg.sv
design/tcdm_amo_unit.sv
design/tcdm_lrsc_monitor.sv
design/tcdm_port_ctrl.sv
design/tcdm_resp_buffer.sv
design/tcdm_adapter.sv
verif/tcdm_adapter_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tcdm_adapter_tb
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tcdm_adapter_tb.sv
`timescale 1ns/1ps

module tcdm_adapter_tb;

  localparam int unsigned clk_period_c       = 100;
  localparam int unsigned reset_cycles_c     = 8;
  localparam int unsigned drive_delay_c      = 10;
  localparam int unsigned cycles_per_entry_c = 20;
  localparam logic [31:0] seed_c             = 32'h22f37548;

  // one row of the stimulus table
  typedef struct packed {
    tcdm_pkg::amo_op_e   op;
    logic                write;
    logic [9:0]          addr;
    logic [31:0]         wdata;
    logic [3:0]          be;
    tcdm_pkg::metadata_t meta;
    logic                resp;
    logic [31:0]         exp;
  } stim_t;

  // response still owed by the DUT
  typedef struct packed {
    logic [7:0]          idx;
    logic [31:0]         data;
    tcdm_pkg::metadata_t meta;
  } expect_t;

  logic                clk_i       = 1'b0;
  logic                rst_ni;
  logic                in_valid_i;
  tcdm_pkg::tcdm_req_t in_req_i;
  logic                in_ready_o;
  logic                in_valid_o;
  logic                in_ready_i  = 1'b0;
  logic [31:0]         in_rdata_o;
  tcdm_pkg::metadata_t in_meta_o;
  tcdm_pkg::bank_req_t out_bank_o;
  logic [31:0]         out_rdata_i = '0;

  logic [31:0]         mem [1024];
  stim_t               table_q [$];
  expect_t             exp_q [$];
  logic                table_ready = 1'b0;
  logic [3:0]          next_id     = 4'd0;
  int unsigned         pass_cnt    = 0;
  int unsigned         fail_cnt    = 0;
  int unsigned         stray_cnt   = 0;
  tcdm_pkg::metadata_t core_a;
  tcdm_pkg::metadata_t core_b;
  tcdm_pkg::metadata_t core_r;

  tcdm_adapter dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .in_valid_i (in_valid_i),
    .in_req_i   (in_req_i),
    .in_ready_o (in_ready_o),
    .in_valid_o (in_valid_o),
    .in_ready_i (in_ready_i),
    .in_rdata_o (in_rdata_o),
    .in_meta_o  (in_meta_o),
    .out_bank_o (out_bank_o),
    .out_rdata_i(out_rdata_i)
  );

  always #(clk_period_c / 2) clk_i = ~clk_i;

  // ----------------------------------------------------------------------
  // sram bank model with read data one cycle after the access
  // ----------------------------------------------------------------------

  always @(posedge clk_i) begin : sram_model
    if (out_bank_o.req) begin
      if (out_bank_o.write) begin
        for (int b = 0; b < 4; b++) begin
          if (out_bank_o.be[b]) begin
            mem[out_bank_o.addr][8*b +: 8] <= out_bank_o.wdata[8*b +: 8];
          end
        end
      end else begin
        out_rdata_i <= mem[out_bank_o.addr];
      end
    end
  end

  // response side back-pressure with ready high about 3 cycles in 4
  initial begin : ready_driver
    void'($urandom(seed_c));
    forever begin
      @(posedge clk_i);
      #(drive_delay_c);
      in_ready_i = ($urandom % 4) != 0;
    end
  end

  // ----------------------------------------------------------------------
  // table building
  // ----------------------------------------------------------------------

  task automatic add_store(input logic [9:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be, input tcdm_pkg::metadata_t who);
    stim_t s;
    s              = '0;
    s.op           = tcdm_pkg::amo_none;
    s.write        = 1'b1;
    s.addr         = addr;
    s.wdata        = wdata;
    s.be           = be;
    s.meta         = who;
    s.meta.meta_id = next_id;
    next_id        = next_id + 4'd1;
    table_q.push_back(s);
  endtask

  // loads, lr, sc and atomics all answer
  task automatic add_req(input tcdm_pkg::amo_op_e op, input logic [9:0] addr,
                         input logic [31:0] wdata, input tcdm_pkg::metadata_t who,
                         input logic [31:0] exp);
    stim_t s;
    s              = '0;
    s.op           = op;
    s.write        = (op == tcdm_pkg::amo_sc);
    s.addr         = addr;
    s.wdata        = wdata;
    s.be           = 4'hf;
    s.meta         = who;
    s.meta.meta_id = next_id;
    s.resp         = 1'b1;
    s.exp          = exp;
    next_id        = next_id + 4'd1;
    table_q.push_back(s);
  endtask

  task automatic build_table();
    // a and r differ only in the remote flag
    core_a = '0;
    core_a.ini_addr.local_core = 2'd1;
    core_a.core_id = 2'd1;
    core_b = '0;
    core_b.ini_addr.local_core = 2'd2;
    core_b.core_id = 2'd1;
    core_r = '0;
    core_r.remote = 1'b1;
    core_r.ini_addr.remote_group = 2'd1;
    core_r.core_id = 2'd1;
    // plain store and load with byte enables and remote metadata
    add_store(10'h010, 32'h1234_5678, 4'hf, core_a);
    add_req(tcdm_pkg::amo_none, 10'h010, 32'h0, core_a, 32'h1234_5678);
    add_store(10'h010, 32'haabb_ccdd, 4'h3, core_a);
    add_req(tcdm_pkg::amo_none, 10'h010, 32'h0, core_r, 32'h1234_ccdd);
    // in the atomic chain each answer is the word left by the one before
    add_store(10'h020, 32'h0000_0010, 4'hf, core_a);
    add_req(tcdm_pkg::amo_swap, 10'h020, 32'hffff_fff0, core_a, 32'h0000_0010);
    add_req(tcdm_pkg::amo_add,  10'h020, 32'h0000_0f2c, core_b, 32'hffff_fff0);
    add_req(tcdm_pkg::amo_and,  10'h020, 32'h0000_0ff0, core_a, 32'h0000_0f1c);
    add_req(tcdm_pkg::amo_or,   10'h020, 32'h8000_0001, core_r, 32'h0000_0f10);
    add_req(tcdm_pkg::amo_xor,  10'h020, 32'h0000_00ff, core_a, 32'h8000_0f11);
    // signed max keeps the positive operand over a negative old word
    add_req(tcdm_pkg::amo_max,  10'h020, 32'h0000_0005, core_b, 32'h8000_0fee);
    add_req(tcdm_pkg::amo_maxu, 10'h020, 32'hffff_fffe, core_a, 32'h0000_0005);
    add_req(tcdm_pkg::amo_min,  10'h020, 32'h0000_0001, core_a, 32'hffff_fffe);
    add_req(tcdm_pkg::amo_minu, 10'h020, 32'h0000_0003, core_b, 32'hffff_fffe);
    add_req(tcdm_pkg::amo_none, 10'h020, 32'h0,         core_a, 32'h0000_0003);
    // lr then sc by the same core
    add_store(10'h030, 32'h1111_1111, 4'hf, core_a);
    add_req(tcdm_pkg::amo_lr,   10'h030, 32'h0,         core_a, 32'h1111_1111);
    add_req(tcdm_pkg::amo_sc,   10'h030, 32'h2222_2222, core_a, 32'h0000_0000);
    add_req(tcdm_pkg::amo_none, 10'h030, 32'h0,         core_a, 32'h2222_2222);
    // sc with no reservation and then sc from the remote look-alike
    add_req(tcdm_pkg::amo_sc,   10'h030, 32'h3333_3333, core_a, 32'h0000_0001);
    add_req(tcdm_pkg::amo_none, 10'h030, 32'h0,         core_a, 32'h2222_2222);
    add_store(10'h040, 32'h4444_4444, 4'hf, core_a);
    add_req(tcdm_pkg::amo_lr,   10'h040, 32'h0,         core_a, 32'h4444_4444);
    add_req(tcdm_pkg::amo_sc,   10'h040, 32'h5555_5555, core_r, 32'h0000_0001);
    add_req(tcdm_pkg::amo_none, 10'h040, 32'h0,         core_a, 32'h4444_4444);
    add_req(tcdm_pkg::amo_sc,   10'h040, 32'h6666_6666, core_a, 32'h0000_0000);
    add_req(tcdm_pkg::amo_none, 10'h040, 32'h0,         core_a, 32'h6666_6666);
    // reservation broken by another core's store and then by its atomic
    add_store(10'h050, 32'h5050_5050, 4'hf, core_b);
    add_req(tcdm_pkg::amo_lr,   10'h050, 32'h0,         core_a, 32'h5050_5050);
    add_store(10'h050, 32'h0505_0505, 4'hf, core_b);
    add_req(tcdm_pkg::amo_sc,   10'h050, 32'h7777_7777, core_a, 32'h0000_0001);
    add_req(tcdm_pkg::amo_none, 10'h050, 32'h0,         core_a, 32'h0505_0505);
    add_req(tcdm_pkg::amo_lr,   10'h050, 32'h0,         core_a, 32'h0505_0505);
    add_req(tcdm_pkg::amo_add,  10'h050, 32'h0000_0001, core_b, 32'h0505_0505);
    add_req(tcdm_pkg::amo_sc,   10'h050, 32'h7777_7777, core_a, 32'h0000_0001);
    add_req(tcdm_pkg::amo_none, 10'h050, 32'h0,         core_a, 32'h0505_0506);
  endtask

  // ----------------------------------------------------------------------
  // driving and reporting
  // ----------------------------------------------------------------------

  function automatic string entry_label(input stim_t s);
    if (s.op == tcdm_pkg::amo_none) begin
      return s.write ? "store" : "load";
    end
    return s.op.name();
  endfunction

  task automatic report_entry(input int idx, input logic bad);
    if (bad) begin
      fail_cnt++;
      $display("entry %0d %s: failed", idx, entry_label(table_q[idx]));
    end else begin
      pass_cnt++;
      $display("entry %0d %s: passed", idx, entry_label(table_q[idx]));
    end
  endtask

  // hold the request until the DUT takes it
  task automatic apply_entry(input int idx);
    stim_t   s;
    expect_t e;
    logic    fire;
    s              = table_q[idx];
    fire           = 1'b0;
    in_valid_i     = 1'b1;
    in_req_i.addr  = s.addr;
    in_req_i.amo   = s.op;
    in_req_i.write = s.write;
    in_req_i.wdata = s.wdata;
    in_req_i.be    = s.be;
    in_req_i.meta  = s.meta;
    while (!fire) begin
      @(negedge clk_i);
      fire = in_ready_o;
      @(posedge clk_i);
      #(drive_delay_c);
    end
    if (s.resp) begin
      e.idx  = idx[7:0];
      e.data = s.exp;
      e.meta = s.meta;
      exp_q.push_back(e);
    end else begin
      report_entry(idx, 1'b0);
    end
  endtask

  // responses are compared in order on each pop
  always @(negedge clk_i) begin : response_check
    expect_t e;
    logic    bad;
    if (rst_ni && in_valid_o && in_ready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("response with meta_id %0d arrived while none was expected",
                 in_meta_o.meta_id);
        stray_cnt++;
      end
      if (exp_q.size() != 0) begin
        e   = exp_q.pop_front();
        bad = 1'b0;
        assert (in_rdata_o === e.data) else begin
          $display("Error at %0d ns: in_rdata_o expected 0x%08h got 0x%08h",
                   $time, e.data, in_rdata_o);
          bad = 1'b1;
        end
        assert (in_meta_o === e.meta) else begin
          $display("Error at %0d ns: in_meta_o expected 0x%03h got 0x%03h",
                   $time, e.meta, in_meta_o);
          bad = 1'b1;
        end
        report_entry(int'(e.idx), bad);
      end
    end
  end

  initial begin : stimulus
    rst_ni     = 1'b0;
    in_valid_i = 1'b0;
    in_req_i   = '0;
    // fill pattern spans the whole word address
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {i[9:0], 6'h15, ~i[9:0], 6'h2a};
    end
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles_c) @(posedge clk_i);
    #(drive_delay_c);
    rst_ni = 1'b1;
    foreach (table_q[i]) begin
      apply_entry(i);
    end
    in_valid_i = 1'b0;
    // drain and leave room for any stray response
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    $display("%0d entries passed, %0d failed, %0d stray responses",
             pass_cnt, fail_cnt, stray_cnt);
    if (fail_cnt == 0 && stray_cnt == 0 && pass_cnt == table_q.size()) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // budget scales with the table length
  initial begin : watchdog
    wait (table_ready);
    #((table_q.size() * cycles_per_entry_c + reset_cycles_c) * clk_period_c);
    $display("timeout, %0d responses still missing", exp_q.size());
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- design/tcdm_adapter.sv
`timescale 1ns/1ps

module tcdm_adapter (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // request side
  input  logic                              in_valid_i,
  input  tcdm_pkg::tcdm_req_t               in_req_i,
  output logic                              in_ready_o,
  // response side
  output logic                              in_valid_o,
  input  logic                              in_ready_i,
  output logic [tcdm_pkg::data_width_c-1:0] in_rdata_o,
  output tcdm_pkg::metadata_t               in_meta_o,
  // sram bank
  output tcdm_pkg::bank_req_t               out_bank_o,
  input  logic [tcdm_pkg::data_width_c-1:0] out_rdata_i
);

  logic                              req_fire;
  logic                              meta_push;
  tcdm_pkg::amo_wb_t                 amo_wb;
  tcdm_pkg::sc_result_t              sc_result;
  logic                              resp_busy;
  logic                              push;
  logic [tcdm_pkg::data_width_c-1:0] push_data;
  tcdm_pkg::metadata_t               push_meta;

  // read-modify-write atomics
  tcdm_amo_unit i_amo_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_fire_i  (req_fire),
    .req_i       (in_req_i),
    .bank_rdata_i(out_rdata_i),
    .amo_wb_o    (amo_wb)
  );

  // lr/sc reservation, watches the bank for breaking writes
  tcdm_lrsc_monitor i_lrsc_monitor (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_fire_i(req_fire),
    .req_i     (in_req_i),
    .bank_i    (out_bank_o),
    .sc_o      (sc_result)
  );

  tcdm_port_ctrl i_port_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .req_i       (in_req_i),
    .in_ready_o  (in_ready_o),
    .req_fire_o  (req_fire),
    .meta_push_o (meta_push),
    .amo_wb_i    (amo_wb),
    .sc_i        (sc_result),
    .bank_o      (out_bank_o),
    .bank_rdata_i(out_rdata_i),
    .resp_busy_i (resp_busy),
    .push_o      (push),
    .push_data_o (push_data),
    .push_meta_o (push_meta)
  );

  // holds the response under back-pressure
  tcdm_resp_buffer i_resp_buffer (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .meta_push_i(meta_push),
    .meta_i     (push_meta),
    .push_i     (push),
    .data_i     (push_data),
    .in_valid_o (in_valid_o),
    .in_ready_i (in_ready_i),
    .in_rdata_o (in_rdata_o),
    .in_meta_o  (in_meta_o),
    .busy_o     (resp_busy)
  );

endmodule

//--- design/tcdm_resp_buffer.sv
`timescale 1ns/1ps

module tcdm_resp_buffer (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              meta_push_i,
  input  tcdm_pkg::metadata_t               meta_i,
  input  logic                              push_i,
  input  logic [tcdm_pkg::data_width_c-1:0] data_i,
  output logic                              in_valid_o,
  input  logic                              in_ready_i,
  output logic [tcdm_pkg::data_width_c-1:0] in_rdata_o,
  output tcdm_pkg::metadata_t               in_meta_o,
  output logic                              busy_o
);

  tcdm_pkg::metadata_t               meta_q [2];
  logic                              meta_wr_q;
  logic                              meta_rd_q;
  logic [1:0]                        meta_cnt_q;
  logic                              meta_valid;
  logic [tcdm_pkg::data_width_c-1:0] data_q;
  logic                              data_full_q;
  logic                              data_valid;
  logic                              pop;

  // ----------------------------------------------------------------------
  // metadata, two entries, registered output
  // ----------------------------------------------------------------------

  assign meta_valid = (meta_cnt_q != 2'd0);
  assign in_meta_o  = meta_q[meta_rd_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_wr_q  <= 1'b0;
      meta_rd_q  <= 1'b0;
      meta_cnt_q <= 2'd0;
    end else begin
      if (meta_push_i) begin
        meta_wr_q <= !meta_wr_q;
      end
      if (pop) begin
        meta_rd_q <= !meta_rd_q;
      end
      // count only moves when push and pop differ
      if (meta_push_i && !pop) begin
        meta_cnt_q <= meta_cnt_q + 2'd1;
      end else if (!meta_push_i && pop) begin
        meta_cnt_q <= meta_cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_q[meta_wr_q] <= meta_i;
    end
  end

  // ----------------------------------------------------------------------
  // read data, one entry, falls through when empty
  // ----------------------------------------------------------------------

  assign data_valid = data_full_q || push_i;
  assign in_rdata_o = data_full_q ? data_q : data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_full_q <= 1'b0;
    end else if (data_full_q && pop) begin
      data_full_q <= 1'b0;
    end else if (push_i && !pop) begin
      data_full_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !data_full_q) begin
      data_q <= data_i;
    end
  end

  // data always trails its metadata, so both valids gate the response
  assign in_valid_o = meta_valid && data_valid;
  assign pop        = in_valid_o && in_ready_i;
  assign busy_o     = in_valid_o && !in_ready_i;

  // port controller must stall before the data entry overflows
  data_no_overflow : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !data_full_q)
    else $error("read data pushed into a full entry");

endmodule

//--- design/tcdm_port_ctrl.sv
`timescale 1ns/1ps

module tcdm_port_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              in_valid_i,
  input  tcdm_pkg::tcdm_req_t               req_i,
  output logic                              in_ready_o,
  output logic                              req_fire_o,
  output logic                              meta_push_o,
  input  tcdm_pkg::amo_wb_t                 amo_wb_i,
  input  tcdm_pkg::sc_result_t              sc_i,
  output tcdm_pkg::bank_req_t               bank_o,
  input  logic [tcdm_pkg::data_width_c-1:0] bank_rdata_i,
  input  logic                              resp_busy_i,
  output logic                              push_o,
  output logic [tcdm_pkg::data_width_c-1:0] push_data_o,
  output tcdm_pkg::metadata_t               push_meta_o
);

  logic is_sc;
  logic push_q;
  logic sc_q;
  logic sc_fail_q;

  // stall on a held response or while an atomic owns the bank
  assign in_ready_o  = !resp_busy_i && !amo_wb_i.valid;
  assign req_fire_o  = in_valid_i && in_ready_o;
  assign is_sc       = (req_i.amo == tcdm_pkg::amo_sc);

  // everything but plain stores gets a response
  assign meta_push_o = req_fire_o && (is_sc || !req_i.write);
  assign push_meta_o = req_i.meta;

  // bank access, atomic write-back has priority
  always_comb begin
    if (amo_wb_i.valid) begin
      bank_o.req   = 1'b1;
      bank_o.write = 1'b1;
      bank_o.addr  = amo_wb_i.addr;
      bank_o.wdata = amo_wb_i.wdata;
      bank_o.be    = '1;
    end else begin
      bank_o.req   = req_fire_o;
      // sc writes only on success, otherwise it reads
      bank_o.write = is_sc ? sc_i.success : req_i.write;
      bank_o.addr  = req_i.addr;
      bank_o.wdata = req_i.wdata;
      bank_o.be    = req_i.be;
    end
  end

  // read data is back one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q    <= 1'b0;
      sc_q      <= 1'b0;
      sc_fail_q <= 1'b0;
    end else begin
      push_q    <= meta_push_o;
      sc_q      <= req_fire_o && is_sc;
      sc_fail_q <= !sc_i.success;
    end
  end

  assign push_o = push_q;

  // sc answers 0 on success, 1 on failure
  assign push_data_o = sc_q ? {{(tcdm_pkg::data_width_c-1){1'b0}}, sc_fail_q} : bank_rdata_i;

  // an accepted atomic blocks the next cycle for its write-back
  amo_blocks_ready : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req_fire_o && (req_i.amo inside {[tcdm_pkg::amo_swap : tcdm_pkg::amo_minu]}))
    |=> !in_ready_o)
    else $error("request accepted during atomic write-back");

endmodule

//--- design/tcdm_lrsc_monitor.sv
`timescale 1ns/1ps

module tcdm_lrsc_monitor (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_fire_i,
  input  tcdm_pkg::tcdm_req_t    req_i,
  input  tcdm_pkg::bank_req_t    bank_i,
  output tcdm_pkg::sc_result_t   sc_o
);

  // one reservation for the whole bank
  typedef struct packed {
    logic                                    valid;
    logic [tcdm_pkg::bank_addr_width_c-1:0]  addr;
    logic [tcdm_pkg::unique_core_width_c-1:0] core;
  } reservation_t;

  reservation_t                             res_d;
  reservation_t                             res_q;
  logic [tcdm_pkg::unique_core_width_c-1:0] unique_core_id;
  logic                                     is_lr;
  logic                                     is_sc;
  logic                                     holder;

  // {group, tile, core} of the requester
  always_comb begin
    if (!req_i.meta.remote) begin
      // local requests take group zero
      unique_core_id = tcdm_pkg::unique_core_width_c'({req_i.meta.tile_id,
                                                       req_i.meta.ini_addr.local_core});
    end else begin
      unique_core_id = {req_i.meta.ini_addr.remote_group,
                        req_i.meta.tile_id,
                        req_i.meta.core_id};
    end
  end

  assign is_lr  = (req_i.amo == tcdm_pkg::amo_lr);
  assign is_sc  = (req_i.amo == tcdm_pkg::amo_sc);
  assign holder = res_q.valid && (res_q.core == unique_core_id);

  // sc passes only for the holder on the reserved word
  assign sc_o.success = req_fire_i && is_sc && holder && (res_q.addr == req_i.addr);

  always_comb begin
    res_d = res_q;
    // any write to the reserved word breaks it
    // covers stores, atomic write-backs and successful sc alike
    if (bank_i.req && bank_i.write && (bank_i.addr == res_q.addr)) begin
      res_d.valid = 1'b0;
    end
    // lr does not steal a reservation held by another core
    if (req_fire_i && is_lr && (!res_q.valid || holder)) begin
      res_d.valid = 1'b1;
      res_d.addr  = req_i.addr;
      res_d.core  = unique_core_id;
    end
    // any sc by the holder ends the reservation whether it passes or not
    if (req_fire_i && is_sc && holder) begin
      res_d.valid = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_q <= '0;
    end else begin
      res_q <= res_d;
    end
  end

  // a passing sc writes the reserved word in the same cycle
  sc_needs_reservation : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    sc_o.success |-> res_q.valid && bank_i.req && bank_i.write &&
                     (bank_i.addr == res_q.addr))
    else $error("sc succeeded without writing the reserved word");

endmodule

//--- design/tcdm_amo_unit.sv
`timescale 1ns/1ps

module tcdm_amo_unit (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_fire_i,
  input  tcdm_pkg::tcdm_req_t                   req_i,
  input  logic [tcdm_pkg::data_width_c-1:0]     bank_rdata_i,
  output tcdm_pkg::amo_wb_t                     amo_wb_o
);

  typedef enum logic {
    amo_idle,
    amo_do
  } amo_state_e;

  amo_state_e                              state_q;
  logic                                    load_amo;
  tcdm_pkg::amo_op_e                       op_q;
  logic [tcdm_pkg::bank_addr_width_c-1:0]  addr_q;
  logic [tcdm_pkg::data_width_c-1:0]       operand_q;

  // shared adder with one extra bit
  // bit 32 is the sign of a - b
  logic [tcdm_pkg::data_width_c:0]         adder_a;
  logic [tcdm_pkg::data_width_c:0]         adder_b;
  logic                                    adder_cin;
  logic [tcdm_pkg::data_width_c:0]         adder_sum;
  logic                                    a_lt_b;
  logic [tcdm_pkg::data_width_c-1:0]       result;

  // only the nine read-modify-write opcodes
  // lr and sc are left to the reservation monitor
  assign load_amo = req_fire_i &&
                    (req_i.amo inside {[tcdm_pkg::amo_swap : tcdm_pkg::amo_minu]});

  // idle -> do for exactly one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= amo_idle;
    end else begin
      state_q <= load_amo ? amo_do : amo_idle;
    end
  end

  // opcode, address and operand of the accepted atomic
  always_ff @(posedge clk_i) begin
    if (load_amo) begin
      op_q      <= req_i.amo;
      addr_q    <= req_i.addr;
      operand_q <= req_i.wdata;
    end
  end

  // ----------------------------------------------------------------------
  // alu
  // ----------------------------------------------------------------------

  // operand a is the old word read back one cycle after acceptance
  always_comb begin
    adder_a   = {bank_rdata_i[tcdm_pkg::data_width_c-1], bank_rdata_i};
    adder_b   = {operand_q[tcdm_pkg::data_width_c-1], operand_q};
    adder_cin = 1'b0;
    unique case (op_q)
      // signed compare as a + ~b + 1
      tcdm_pkg::amo_max, tcdm_pkg::amo_min: begin
        adder_b   = ~{operand_q[tcdm_pkg::data_width_c-1], operand_q};
        adder_cin = 1'b1;
      end
      // unsigned compare on zero-extended operands
      tcdm_pkg::amo_maxu, tcdm_pkg::amo_minu: begin
        adder_a   = {1'b0, bank_rdata_i};
        adder_b   = ~{1'b0, operand_q};
        adder_cin = 1'b1;
      end
      default: ;
    endcase
  end

  assign adder_sum = adder_a + adder_b + {{tcdm_pkg::data_width_c{1'b0}}, adder_cin};
  assign a_lt_b    = adder_sum[tcdm_pkg::data_width_c];

  always_comb begin
    unique case (op_q)
      tcdm_pkg::amo_swap: result = operand_q;
      tcdm_pkg::amo_add:  result = adder_sum[tcdm_pkg::data_width_c-1:0];
      tcdm_pkg::amo_and:  result = bank_rdata_i & operand_q;
      tcdm_pkg::amo_or:   result = bank_rdata_i | operand_q;
      tcdm_pkg::amo_xor:  result = bank_rdata_i ^ operand_q;
      // keep the larger one
      tcdm_pkg::amo_max, tcdm_pkg::amo_maxu: result = a_lt_b ? operand_q : bank_rdata_i;
      // keep the smaller one
      tcdm_pkg::amo_min, tcdm_pkg::amo_minu: result = a_lt_b ? bank_rdata_i : operand_q;
      default: result = '0;
    endcase
  end

  // write-back claims the bank with all bytes in the do cycle
  assign amo_wb_o.valid = (state_q == amo_do);
  assign amo_wb_o.addr  = addr_q;
  assign amo_wb_o.wdata = result;

  // back-to-back atomics must be separated by the write-back cycle
  wb_single_cycle : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    amo_wb_o.valid |=> !amo_wb_o.valid)
    else $error("atomic write-back held for two cycles");

endmodule

//--- design/tcdm_pkg.sv
package tcdm_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------

  // the bank supports 32-bit words only
  localparam int unsigned data_width_c        = 32;
  localparam int unsigned be_width_c          = data_width_c / 8;
  // word address into the bank
  localparam int unsigned bank_addr_width_c   = 10;
  localparam int unsigned meta_id_width_c     = 4;
  localparam int unsigned core_id_width_c     = 2;
  localparam int unsigned tile_id_width_c     = 2;
  // msb flags a remote request, low bits are decoded through ini_addr_u
  localparam int unsigned ini_addr_width_c    = 3;
  // group, tile and core, two bits each
  localparam int unsigned unique_core_width_c = 6;

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------

  // atomic opcode, encodings 0 to 11
  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9,
    amo_lr   = 4'ha,
    amo_sc   = 4'hb
  } amo_op_e;

  // local request: core inside the tile
  // remote request: the requesting group
  typedef union packed {
    logic [ini_addr_width_c-2:0] local_core;
    logic [ini_addr_width_c-2:0] remote_group;
  } ini_addr_u;

  typedef struct packed {
    logic                       remote;
    ini_addr_u                  ini_addr;
    logic [tile_id_width_c-1:0] tile_id;
    logic [core_id_width_c-1:0] core_id;
    logic [meta_id_width_c-1:0] meta_id;
  } metadata_t;

  // incoming request
  typedef struct packed {
    logic [bank_addr_width_c-1:0] addr;
    amo_op_e                      amo;
    logic                         write;
    logic [data_width_c-1:0]      wdata;
    logic [be_width_c-1:0]        be;
    metadata_t                    meta;
  } tcdm_req_t;

  // sram bank access
  typedef struct packed {
    logic                         req;
    logic                         write;
    logic [bank_addr_width_c-1:0] addr;
    logic [data_width_c-1:0]      wdata;
    logic [be_width_c-1:0]        be;
  } bank_req_t;

  // atomic write-back into the bank
  typedef struct packed {
    logic                         valid;
    logic [bank_addr_width_c-1:0] addr;
    logic [data_width_c-1:0]      wdata;
  } amo_wb_t;

  // store-conditional verdict, combinational in the accept cycle
  typedef struct packed {
    logic success;
  } sc_result_t;

endpackage
